// ==== source/iss_pkg.sv ====
package iss_pkg;

  // Queue slots presented to issue each cycle
  localparam int unsigned ISSUE_WIDTH = 2;

  // Operand and PC width
  localparam int unsigned DATA_WIDTH = 32;

  // Return address sits past the branch and its following slot
  localparam int unsigned LINK_OFFSET = 8;

  typedef logic [DATA_WIDTH-1:0] data_t;

  // Architectural register number
  typedef logic [4:0] reg_addr_t;

  // Reorder buffer entry index
  typedef logic [3:0] rob_slot_t;

  // Execution unit the instruction is steered to
  typedef enum logic [1:0] {
    CLASS_ALU    = 2'd0,
    CLASS_LS     = 2'd1,
    CLASS_BRANCH = 2'd2,
    CLASS_JUMP   = 2'd3
  } inst_class_e;

  // Branch conditions, evaluated on A against zero or on A against B
  typedef enum logic [2:0] {
    COND_UNCOND = 3'd0,
    COND_EQ     = 3'd1,
    COND_NE     = 3'd2,
    COND_GT     = 3'd3,
    COND_GE     = 3'd4,
    COND_LT     = 3'd5,
    COND_LE     = 3'd6
  } branch_cond_e;

endpackage

// ==== source/operand_fetch.sv ====
module operand_fetch import iss_pkg::*; (
  // Which source operands each slot actually reads
  input  logic  slot_a_used   [ISSUE_WIDTH],
  input  logic  slot_b_used   [ISSUE_WIDTH],

  // ROB associative lookup results
  input  logic  rob_a_present [ISSUE_WIDTH],
  input  logic  rob_a_valid   [ISSUE_WIDTH],
  input  data_t rob_a_value   [ISSUE_WIDTH],
  input  logic  rob_b_present [ISSUE_WIDTH],
  input  logic  rob_b_valid   [ISSUE_WIDTH],
  input  data_t rob_b_value   [ISSUE_WIDTH],

  // Register file read data, A at 2i and B at 2i+1
  input  data_t rd_data       [ISSUE_WIDTH*2],

  output data_t op_a          [ISSUE_WIDTH],
  output data_t op_b          [ISSUE_WIDTH],
  output logic  ops_ready     [ISSUE_WIDTH]
);

  logic a_ready [ISSUE_WIDTH];
  logic b_ready [ISSUE_WIDTH];

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot

    // A pending ROB entry holds the newest value of the register
    assign op_a[i] = rob_a_present[i] ? rob_a_value[i] : rd_data[2*i];
    assign op_b[i] = rob_b_present[i] ? rob_b_value[i] : rd_data[2*i+1];

    // Absent from the ROB means the register file is already current
    assign a_ready[i] = !rob_a_present[i] || rob_a_valid[i];
    assign b_ready[i] = !rob_b_present[i] || rob_b_valid[i];

    // Operands the instruction does not read never hold it back
    assign ops_ready[i] = (a_ready[i] || !slot_a_used[i]) &&
                          (b_ready[i] || !slot_b_used[i]);

  end

endmodule

// ==== source/issue_select.sv ====
module issue_select import iss_pkg::*; (
  input  logic         clock,
  input  logic         reset_n,

  // Instruction queue slots, slot 0 oldest
  input  logic         slot_valid     [ISSUE_WIDTH],
  input  inst_class_e  slot_class     [ISSUE_WIDTH],
  input  rob_slot_t    slot_rob_slot  [ISSUE_WIDTH],
  input  data_t        slot_pc        [ISSUE_WIDTH],
  input  branch_cond_e slot_cond      [ISSUE_WIDTH],
  input  data_t        slot_target    [ISSUE_WIDTH],
  input  logic         slot_rformat   [ISSUE_WIDTH],
  input  reg_addr_t    slot_dest_reg  [ISSUE_WIDTH],
  input  logic         slot_dest_used [ISSUE_WIDTH],

  // Selected operands and their readiness
  input  data_t        op_a           [ISSUE_WIDTH],
  input  data_t        op_b           [ISSUE_WIDTH],
  input  logic         ops_ready      [ISSUE_WIDTH],

  // Unit availability
  input  logic         ls_ready,
  input  logic         alu_ready,
  input  logic         branch_stall,

  output logic         slot_consumed  [ISSUE_WIDTH],

  // Load/store dispatch
  output logic         ls_valid,
  output data_t        ls_a,
  output data_t        ls_b,
  output rob_slot_t    ls_rob_slot,

  // ALU dispatch
  output logic         alu_valid,
  output data_t        alu_a,
  output data_t        alu_b,
  output rob_slot_t    alu_rob_slot,

  // Branch unit request, same cycle
  output logic         br_issue,
  output inst_class_e  br_class,
  output branch_cond_e br_cond,
  output data_t        br_pc,
  output data_t        br_target,
  output logic         br_rformat,
  output data_t        br_a,
  output data_t        br_b,
  output rob_slot_t    br_rob_slot,
  output reg_addr_t    br_dest_reg,
  output logic         br_dest_used
);

  logic      ls_take;
  data_t     ls_a_next;
  data_t     ls_b_next;
  rob_slot_t ls_rob_slot_next;

  logic      alu_take;
  data_t     alu_a_next;
  data_t     alu_b_next;
  rob_slot_t alu_rob_slot_next;

  // In-order scan, the first slot that cannot go stops all younger ones
  always_comb begin
    logic blocked;

    blocked           = 1'b0;

    ls_take           = 1'b0;
    ls_a_next         = op_a[0];
    ls_b_next         = op_b[0];
    ls_rob_slot_next  = slot_rob_slot[0];

    alu_take          = 1'b0;
    alu_a_next        = op_a[0];
    alu_b_next        = op_b[0];
    alu_rob_slot_next = slot_rob_slot[0];

    br_issue          = 1'b0;
    br_class          = slot_class[0];
    br_cond           = slot_cond[0];
    br_pc             = slot_pc[0];
    br_target         = slot_target[0];
    br_rformat        = slot_rformat[0];
    br_a              = op_a[0];
    br_b              = op_b[0];
    br_rob_slot       = slot_rob_slot[0];
    br_dest_reg       = slot_dest_reg[0];
    br_dest_used      = slot_dest_used[0];

    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      slot_consumed[i] = 1'b0;

      if (!blocked && slot_valid[i] && ops_ready[i]) begin
        case (slot_class[i])
          CLASS_BRANCH, CLASS_JUMP: begin
            // One branch per cycle, and only while fetch can take a redirect
            if (!br_issue && !branch_stall) begin
              slot_consumed[i] = 1'b1;
              br_issue         = 1'b1;
              br_class         = slot_class[i];
              br_cond          = slot_cond[i];
              br_pc            = slot_pc[i];
              br_target        = slot_target[i];
              br_rformat       = slot_rformat[i];
              br_a             = op_a[i];
              br_b             = op_b[i];
              br_rob_slot      = slot_rob_slot[i];
              br_dest_reg      = slot_dest_reg[i];
              br_dest_used     = slot_dest_used[i];
            end
          end
          CLASS_LS: begin
            if (!ls_take && ls_ready) begin
              slot_consumed[i] = 1'b1;
              ls_take          = 1'b1;
              ls_a_next        = op_a[i];
              ls_b_next        = op_b[i];
              ls_rob_slot_next = slot_rob_slot[i];
            end
          end
          default: begin
            if (!alu_take && alu_ready) begin
              slot_consumed[i]  = 1'b1;
              alu_take          = 1'b1;
              alu_a_next        = op_a[i];
              alu_b_next        = op_b[i];
              alu_rob_slot_next = slot_rob_slot[i];
            end
          end
        endcase
      end

      if (!slot_consumed[i]) begin
        blocked = 1'b1;
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ls_valid  <= 1'b0;
      alu_valid <= 1'b0;
    end else begin
      ls_valid  <= ls_take;
      alu_valid <= alu_take;
    end
  end

  // Dispatch payload, only meaningful alongside its valid
  always_ff @(posedge clock) begin
    if (ls_take) begin
      ls_a        <= ls_a_next;
      ls_b        <= ls_b_next;
      ls_rob_slot <= ls_rob_slot_next;
    end
    if (alu_take) begin
      alu_a        <= alu_a_next;
      alu_b        <= alu_b_next;
      alu_rob_slot <= alu_rob_slot_next;
    end
  end

endmodule

// ==== source/branch_resolve.sv ====
module branch_resolve import iss_pkg::*; (
  input  logic         clock,
  input  logic         reset_n,

  // Branch or jump picked by issue this cycle
  input  logic         br_issue,
  input  inst_class_e  br_class,
  input  branch_cond_e br_cond,
  input  data_t        br_pc,
  input  data_t        br_target,
  input  logic         br_rformat,
  input  data_t        br_a,
  input  data_t        br_b,
  input  rob_slot_t    br_rob_slot,
  input  reg_addr_t    br_dest_reg,
  input  logic         br_dest_used,

  // Redirect toward fetch
  output data_t        new_pc,
  output logic         new_pc_valid,

  // Link register write into the ROB
  output logic         wr_valid,
  output rob_slot_t    wr_slot,
  output data_t        wr_data,
  output reg_addr_t    wr_dest_reg,
  output logic         wr_dest_used
);

  logic a_eq_b;
  logic a_eqz;
  logic a_gez;
  logic a_gtz;
  logic cond_ok;
  logic taken;

  // A is compared as a signed value against zero
  assign a_eq_b = (br_a == br_b);
  assign a_eqz  = (br_a == '0);
  assign a_gez  = !br_a[DATA_WIDTH-1];
  assign a_gtz  = a_gez && !a_eqz;

  always_comb begin
    case (br_cond)
      COND_UNCOND: cond_ok = 1'b1;
      COND_EQ:     cond_ok = a_eq_b;
      COND_NE:     cond_ok = !a_eq_b;
      COND_GT:     cond_ok = a_gtz;
      COND_GE:     cond_ok = a_gez;
      COND_LT:     cond_ok = !a_gez;
      COND_LE:     cond_ok = !a_gtz;
      default:     cond_ok = 1'b0;
    endcase
  end

  // Jumps always redirect, branches only when the condition holds
  assign taken = (br_class == CLASS_JUMP) || ((br_class == CLASS_BRANCH) && cond_ok);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      new_pc_valid <= 1'b0;
      wr_valid     <= 1'b0;
    end else begin
      new_pc_valid <= br_issue && taken;
      wr_valid     <= br_issue;
    end
  end

  always_ff @(posedge clock) begin
    if (br_issue) begin
      // Register-format jumps take their target from operand A
      new_pc       <= br_rformat ? br_a : br_target;
      wr_slot      <= br_rob_slot;
      wr_data      <= br_pc + data_t'(LINK_OFFSET);
      wr_dest_reg  <= br_dest_reg;
      wr_dest_used <= br_dest_used;
    end
  end

endmodule

// ==== source/iss_top.sv ====
module iss_top import iss_pkg::*; (
  input  logic         clock,
  input  logic         reset_n,

  // Instruction queue
  input  logic         slot_valid     [ISSUE_WIDTH],
  input  inst_class_e  slot_class     [ISSUE_WIDTH],
  input  reg_addr_t    slot_a_reg     [ISSUE_WIDTH],
  input  logic         slot_a_used    [ISSUE_WIDTH],
  input  reg_addr_t    slot_b_reg     [ISSUE_WIDTH],
  input  logic         slot_b_used    [ISSUE_WIDTH],
  input  rob_slot_t    slot_rob_slot  [ISSUE_WIDTH],
  input  data_t        slot_pc        [ISSUE_WIDTH],
  input  branch_cond_e slot_cond      [ISSUE_WIDTH],
  input  data_t        slot_target    [ISSUE_WIDTH],
  input  logic         slot_rformat   [ISSUE_WIDTH],
  input  reg_addr_t    slot_dest_reg  [ISSUE_WIDTH],
  input  logic         slot_dest_used [ISSUE_WIDTH],
  output logic         slot_consumed  [ISSUE_WIDTH],

  // ROB lookup
  input  logic         rob_a_present  [ISSUE_WIDTH],
  input  logic         rob_a_valid    [ISSUE_WIDTH],
  input  data_t        rob_a_value    [ISSUE_WIDTH],
  input  logic         rob_b_present  [ISSUE_WIDTH],
  input  logic         rob_b_valid    [ISSUE_WIDTH],
  input  data_t        rob_b_value    [ISSUE_WIDTH],

  // Register file read ports
  output reg_addr_t    rd_addr        [ISSUE_WIDTH*2],
  input  data_t        rd_data        [ISSUE_WIDTH*2],

  // Load/store unit
  output logic         ls_valid,
  output data_t        ls_a,
  output data_t        ls_b,
  output rob_slot_t    ls_rob_slot,
  input  logic         ls_ready,

  // ALU
  output logic         alu_valid,
  output data_t        alu_a,
  output data_t        alu_b,
  output rob_slot_t    alu_rob_slot,
  input  logic         alu_ready,

  // Fetch redirect and link write
  input  logic         branch_stall,
  output data_t        new_pc,
  output logic         new_pc_valid,
  output logic         wr_valid,
  output rob_slot_t    wr_slot,
  output data_t        wr_data,
  output reg_addr_t    wr_dest_reg,
  output logic         wr_dest_used
);

  data_t        op_a      [ISSUE_WIDTH];
  data_t        op_b      [ISSUE_WIDTH];
  logic         ops_ready [ISSUE_WIDTH];

  logic         br_issue;
  inst_class_e  br_class;
  branch_cond_e br_cond;
  data_t        br_pc;
  data_t        br_target;
  logic         br_rformat;
  data_t        br_a;
  data_t        br_b;
  rob_slot_t    br_rob_slot;
  reg_addr_t    br_dest_reg;
  logic         br_dest_used;

  // Two read ports per slot
  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_rd_addr
    assign rd_addr[2*i]   = slot_a_reg[i];
    assign rd_addr[2*i+1] = slot_b_reg[i];
  end

  operand_fetch u_operand_fetch (
    .slot_a_used   (slot_a_used),
    .slot_b_used   (slot_b_used),
    .rob_a_present (rob_a_present),
    .rob_a_valid   (rob_a_valid),
    .rob_a_value   (rob_a_value),
    .rob_b_present (rob_b_present),
    .rob_b_valid   (rob_b_valid),
    .rob_b_value   (rob_b_value),
    .rd_data       (rd_data),
    .op_a          (op_a),
    .op_b          (op_b),
    .ops_ready     (ops_ready)
  );

  issue_select u_issue_select (
    .clock          (clock),
    .reset_n        (reset_n),
    .slot_valid     (slot_valid),
    .slot_class     (slot_class),
    .slot_rob_slot  (slot_rob_slot),
    .slot_pc        (slot_pc),
    .slot_cond      (slot_cond),
    .slot_target    (slot_target),
    .slot_rformat   (slot_rformat),
    .slot_dest_reg  (slot_dest_reg),
    .slot_dest_used (slot_dest_used),
    .op_a           (op_a),
    .op_b           (op_b),
    .ops_ready      (ops_ready),
    .ls_ready       (ls_ready),
    .alu_ready      (alu_ready),
    .branch_stall   (branch_stall),
    .slot_consumed  (slot_consumed),
    .ls_valid       (ls_valid),
    .ls_a           (ls_a),
    .ls_b           (ls_b),
    .ls_rob_slot    (ls_rob_slot),
    .alu_valid      (alu_valid),
    .alu_a          (alu_a),
    .alu_b          (alu_b),
    .alu_rob_slot   (alu_rob_slot),
    .br_issue       (br_issue),
    .br_class       (br_class),
    .br_cond        (br_cond),
    .br_pc          (br_pc),
    .br_target      (br_target),
    .br_rformat     (br_rformat),
    .br_a           (br_a),
    .br_b           (br_b),
    .br_rob_slot    (br_rob_slot),
    .br_dest_reg    (br_dest_reg),
    .br_dest_used   (br_dest_used)
  );

  branch_resolve u_branch_resolve (
    .clock        (clock),
    .reset_n      (reset_n),
    .br_issue     (br_issue),
    .br_class     (br_class),
    .br_cond      (br_cond),
    .br_pc        (br_pc),
    .br_target    (br_target),
    .br_rformat   (br_rformat),
    .br_a         (br_a),
    .br_b         (br_b),
    .br_rob_slot  (br_rob_slot),
    .br_dest_reg  (br_dest_reg),
    .br_dest_used (br_dest_used),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid),
    .wr_valid     (wr_valid),
    .wr_slot      (wr_slot),
    .wr_data      (wr_data),
    .wr_dest_reg  (wr_dest_reg),
    .wr_dest_used (wr_dest_used)
  );

endmodule

// ==== testbench/iss_asserts.sv ====
module iss_asserts import iss_pkg::*; (
  input logic clock,
  input logic reset_n,
  input logic ls_valid,
  input logic alu_valid,
  input logic new_pc_valid,
  input logic wr_valid,
  input logic slot_consumed [ISSUE_WIDTH]
);

  // All unit outputs stay quiet while reset is held
  a_quiet_in_reset: assert property (@(posedge clock)
    !reset_n |-> !(ls_valid || alu_valid || new_pc_valid || wr_valid))
    else $error("valid output high during reset");

  // Issue is in order, slot 1 never goes without slot 0
  a_in_order: assert property (@(posedge clock) disable iff (!reset_n)
    slot_consumed[1] |-> slot_consumed[0])
    else $error("slot 1 consumed without slot 0");

  // Every redirect comes with a link write
  a_redirect_link: assert property (@(posedge clock) disable iff (!reset_n)
    new_pc_valid |-> wr_valid)
    else $error("new_pc_valid without wr_valid");

endmodule

bind iss_top iss_asserts u_asserts (.*);

// ==== testbench/iss_tb.sv ====
module iss_tb import iss_pkg::*; ();

  localparam int unsigned MAX_LINES     = 200;
  localparam int unsigned RESET_TIMEOUT = 20;

  logic         clock;
  logic         reset_n;
  logic         slot_valid     [ISSUE_WIDTH];
  inst_class_e  slot_class     [ISSUE_WIDTH];
  reg_addr_t    slot_a_reg     [ISSUE_WIDTH];
  logic         slot_a_used    [ISSUE_WIDTH];
  reg_addr_t    slot_b_reg     [ISSUE_WIDTH];
  logic         slot_b_used    [ISSUE_WIDTH];
  rob_slot_t    slot_rob_slot  [ISSUE_WIDTH];
  data_t        slot_pc        [ISSUE_WIDTH];
  branch_cond_e slot_cond      [ISSUE_WIDTH];
  data_t        slot_target    [ISSUE_WIDTH];
  logic         slot_rformat   [ISSUE_WIDTH];
  reg_addr_t    slot_dest_reg  [ISSUE_WIDTH];
  logic         slot_dest_used [ISSUE_WIDTH];
  logic         slot_consumed  [ISSUE_WIDTH];
  logic         rob_a_present  [ISSUE_WIDTH];
  logic         rob_a_valid    [ISSUE_WIDTH];
  data_t        rob_a_value    [ISSUE_WIDTH];
  logic         rob_b_present  [ISSUE_WIDTH];
  logic         rob_b_valid    [ISSUE_WIDTH];
  data_t        rob_b_value    [ISSUE_WIDTH];
  reg_addr_t    rd_addr        [ISSUE_WIDTH*2];
  data_t        rd_data        [ISSUE_WIDTH*2];
  logic         ls_valid, alu_valid, ls_ready, alu_ready, branch_stall;
  data_t        ls_a, ls_b, alu_a, alu_b, new_pc, wr_data;
  rob_slot_t    ls_rob_slot, alu_rob_slot, wr_slot;
  logic         new_pc_valid, wr_valid, wr_dest_used;
  reg_addr_t    wr_dest_reg;

  int           err_count;
  int           fail_tests;
  int           tests;
  int           err_start;

  // Expected results of the test driven in the previous cycle
  string        p_name;
  logic [3:0]   p_vld;
  data_t        p_la, p_lb, p_aa, p_ab, p_npc, p_wd;
  rob_slot_t    p_lr, p_ar, p_ws;

  iss_top u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Register file model, each register reads back 0xf00 plus its number
  for (genvar k = 0; k < ISSUE_WIDTH*2; k++) begin : g_regfile
    assign rd_data[k] = 32'h0000_0f00 + data_t'(rd_addr[k]);
  end

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic check_consumed(input logic exp [ISSUE_WIDTH], input logic got [ISSUE_WIDTH]);
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      if (got[i] !== exp[i]) begin
        report_error($sformatf("slot_consumed[%0d] is %b, expected %b", i, got[i], exp[i]));
      end
    end
  endtask

  task automatic check_dispatch(input string unit, input logic exp_v, input logic got_v,
                                input data_t exp_a, input data_t got_a,
                                input data_t exp_b, input data_t got_b,
                                input rob_slot_t exp_r, input rob_slot_t got_r);
    if (got_v !== exp_v) begin
      report_error($sformatf("%s valid is %b, expected %b", unit, got_v, exp_v));
    end else if (exp_v && (got_a !== exp_a || got_b !== exp_b || got_r !== exp_r)) begin
      report_error($sformatf("%s a/b/rob %h/%h/%h, expected %h/%h/%h", unit,
                             got_a, got_b, got_r, exp_a, exp_b, exp_r));
    end
  endtask

  task automatic check_branch(input logic exp_pcv, input logic got_pcv,
                              input data_t exp_pc, input data_t got_pc,
                              input logic exp_wv, input logic got_wv,
                              input data_t exp_wd, input data_t got_wd,
                              input rob_slot_t exp_ws, input rob_slot_t got_ws,
                              input reg_addr_t exp_wr, input reg_addr_t got_wr,
                              input logic exp_wu, input logic got_wu);
    if (got_pcv !== exp_pcv || got_wv !== exp_wv) begin
      report_error($sformatf("new_pc_valid/wr_valid %b/%b, expected %b/%b",
                             got_pcv, got_wv, exp_pcv, exp_wv));
    end
    if (exp_pcv && got_pcv === 1'b1 && got_pc !== exp_pc) begin
      report_error($sformatf("new_pc %h, expected %h", got_pc, exp_pc));
    end
    if (exp_wv && got_wv === 1'b1 && (got_wd !== exp_wd || got_ws !== exp_ws ||
                                      got_wr !== exp_wr || got_wu !== exp_wu)) begin
      report_error($sformatf("link data/slot/reg/used %h/%h/%0d/%b, expected %h/%h/%0d/%b",
                             got_wd, got_ws, got_wr, got_wu,
                             exp_wd, exp_ws, exp_wr, exp_wu));
    end
  endtask

  // Flags byte is v, rformat, a_used, b_used, a_present, a_valid, b_present, b_valid
  task automatic drive_slot(input int i, input logic [7:0] f, input logic [7:0] cc,
                            input data_t a, input data_t b, input data_t pc,
                            input data_t tgt, input rob_slot_t r);
    slot_valid[i]     <= f[7];
    slot_rformat[i]   <= f[6];
    slot_a_used[i]    <= f[5];
    slot_b_used[i]    <= f[4];
    rob_a_present[i]  <= f[3];
    rob_a_valid[i]    <= f[2];
    rob_b_present[i]  <= f[1];
    rob_b_valid[i]    <= f[0];
    slot_class[i]     <= inst_class_e'(cc[5:4]);
    slot_cond[i]      <= branch_cond_e'(cc[2:0]);
    rob_a_value[i]    <= a;
    rob_b_value[i]    <= b;
    slot_pc[i]        <= pc;
    slot_target[i]    <= tgt;
    slot_rob_slot[i]  <= r;
    // Link destination follows the ROB tag, so each branch writes its own register
    slot_dest_reg[i]  <= {1'b1, r};
    slot_dest_used[i] <= r[0];
  endtask

  // Dispatch and branch results register one cycle after their test is driven
  task automatic finish_test();
    check_dispatch("ls", p_vld[3], ls_valid, p_la, ls_a, p_lb, ls_b, p_lr, ls_rob_slot);
    check_dispatch("alu", p_vld[2], alu_valid, p_aa, alu_a, p_ab, alu_b, p_ar, alu_rob_slot);
    check_branch(p_vld[1], new_pc_valid, p_npc, new_pc, p_vld[0], wr_valid, p_wd, wr_data,
                 p_ws, wr_slot, {1'b1, p_ws}, wr_dest_reg, p_ws[0], wr_dest_used);
    tests++;
    if (err_count != err_start) begin
      fail_tests++;
    end
    $display("test %0d %s: %s", tests, p_name, (err_count == err_start) ? "ok" : "failed");
  endtask

  initial begin
    int         fd;
    int         n;
    int         lines;
    int         cnt;
    string      line;
    string      name;
    string      abort_msg;
    logic [7:0] f0, c0, f1, c1;
    data_t      a0, b0, pc0, t0, a1, b1, pc1, t1;
    rob_slot_t  r0, r1;
    logic [3:0] rdy, e_vld;
    logic [1:0] e_cons;
    data_t      e_la, e_lb, e_aa, e_ab, e_npc, e_wd;
    rob_slot_t  e_lr, e_ar;
    logic       exp_cons [ISSUE_WIDTH];
    logic       have_prev;

    err_count  = 0;
    fail_tests = 0;
    lines      = 0;
    tests      = 0;
    have_prev  = 1'b0;
    err_start  = 0;
    abort_msg  = "";
    fd         = 0;
    reset_n      <= 1'b0;
    ls_ready     <= 1'b0;
    alu_ready    <= 1'b0;
    branch_stall <= 1'b0;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      drive_slot(i, 8'h00, 8'h00, '0, '0, '0, '0, '0);
      slot_a_reg[i] <= reg_addr_t'(2*i);
      slot_b_reg[i] <= reg_addr_t'(2*i+1);
    end

    repeat (8) @(posedge clock);
    reset_n <= 1'b1;
    cnt = 0;
    while (reset_n !== 1'b1 && cnt < RESET_TIMEOUT) begin
      @(posedge clock);
      cnt++;
    end
    if (reset_n !== 1'b1) begin
      abort_msg = "Reset was not released in time";
    end else begin
      fd = $fopen("testbench/iss_input.txt", "r");
      if (fd == 0) begin
        abort_msg = "Could not open the stimulus file testbench/iss_input.txt";
      end
    end

    while (abort_msg == "" && !$feof(fd) && lines < MAX_LINES) begin
      lines++;
      n = $fgets(line, fd);
      if (n > 8 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s",
                    f0, c0, a0, b0, pc0, t0, r0, f1, c1, a1, b1, pc1, t1, r1, rdy,
                    e_cons, e_vld, e_la, e_lb, e_lr, e_aa, e_ab, e_ar, e_npc, e_wd, name);
        if (n != 26) begin
          abort_msg = $sformatf("Stimulus line %0d could not be parsed", lines);
        end else begin
          @(posedge clock);
          drive_slot(0, f0, c0, a0, b0, pc0, t0, r0);
          drive_slot(1, f1, c1, a1, b1, pc1, t1, r1);
          ls_ready     <= rdy[2];
          alu_ready    <= rdy[1];
          branch_stall <= rdy[0];
          @(negedge clock);
          if (have_prev) begin
            finish_test();
          end
          err_start   = err_count;
          exp_cons[0] = e_cons[0];
          exp_cons[1] = e_cons[1];
          check_consumed(exp_cons, slot_consumed);
          p_vld  = e_vld;
          p_la   = e_la;
          p_lb   = e_lb;
          p_lr   = e_lr;
          p_aa   = e_aa;
          p_ab   = e_ab;
          p_ar   = e_ar;
          p_npc  = e_npc;
          p_wd   = e_wd;
          // The branch unit serves slot 0 whenever slot 0 holds the branch
          p_ws   = c0[5] ? r0 : r1;
          p_name = name;
          have_prev = 1'b1;
        end
      end
    end
    if (abort_msg == "" && !$feof(fd)) begin
      abort_msg = "Stimulus file did not end within the line limit";
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    // Idle cycle flushes the last test's results
    if (abort_msg == "" && have_prev) begin
      @(posedge clock);
      drive_slot(0, 8'h00, 8'h00, '0, '0, '0, '0, '0);
      drive_slot(1, 8'h00, 8'h00, '0, '0, '0, '0, '0);
      @(negedge clock);
      finish_test();
    end

    if (abort_msg != "") begin
      $display("%s", abort_msg);
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests, fail_tests, err_count);
    if (abort_msg == "" && err_count == 0 && tests > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/iss_input.txt ====
# s0: flags cls_cond a b pc target rob | s1: same | rdy(ls,alu,stall)
# exp: cons vld(ls,alu,pcv,wv) ls_a ls_b ls_rob alu_a alu_b alu_rob new_pc wr_data name
bc 10 1234 0 100 0 3 00 00 0 0 0 0 0 6 1 8 1234 f01 3 0 0 0 0 0 opsel_rob
b0 00 0 0 100 0 5 b3 10 0 55aa 104 0 6 6 3 c f02 55aa 6 f00 f01 5 0 0 opsel_rf
b0 10 0 0 100 0 1 b0 00 0 0 104 0 2 6 3 c f00 f01 1 f02 f03 2 0 0 dual
a8 00 dead 0 100 0 3 b0 10 0 0 104 0 4 6 0 0 0 0 0 0 0 0 0 0 notready
98 00 dead 0 100 0 7 00 00 0 0 0 0 0 6 1 4 0 0 0 dead f01 7 0 0 unused_pend
b0 00 0 0 100 0 4 b0 00 0 0 104 0 5 6 1 4 0 0 0 f00 f01 4 0 0 two_alu
b0 00 0 0 100 0 4 b0 10 0 0 104 0 5 4 0 0 0 0 0 0 0 0 0 0 alu_busy
b0 10 0 0 100 0 4 b0 00 0 0 104 0 5 2 0 0 0 0 0 0 0 0 0 0 ls_busy
bf 21 5 5 200 400 8 b0 00 0 0 204 0 9 7 0 0 0 0 0 0 0 0 0 0 br_stall
bf 20 0 0 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 uncond
bf 21 5 5 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 eq_taken
bf 21 5 6 200 400 8 00 00 0 0 0 0 0 6 1 1 0 0 0 0 0 0 400 208 eq_not
bf 22 5 6 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 ne_taken
bf 22 5 5 200 400 8 00 00 0 0 0 0 0 6 1 1 0 0 0 0 0 0 400 208 ne_not
bf 23 1 0 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 gt_taken
bf 23 0 0 200 400 8 00 00 0 0 0 0 0 6 1 1 0 0 0 0 0 0 400 208 gt_not
bf 24 0 0 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 ge_taken
bf 24 ffffffff 0 200 400 8 00 00 0 0 0 0 0 6 1 1 0 0 0 0 0 0 400 208 ge_not
bf 25 ffffffff 0 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 lt_taken
bf 25 0 0 200 400 8 00 00 0 0 0 0 0 6 1 1 0 0 0 0 0 0 400 208 lt_not
bf 26 0 0 200 400 8 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 400 208 le_taken
bf 26 7 0 200 400 8 00 00 0 0 0 0 0 6 1 1 0 0 0 0 0 0 400 208 le_not
80 30 0 0 300 500 a 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 500 308 jump
ec 30 abc0 0 310 500 b 00 00 0 0 0 0 0 6 1 3 0 0 0 0 0 0 abc0 318 jump_reg
ac 23 1 0 200 400 8 b0 10 0 0 204 0 9 6 3 b f02 f03 9 0 0 0 400 208 br_ls_dual

// ==== tb.f ====
source/iss_pkg.sv
source/operand_fetch.sv
source/issue_select.sv
source/branch_resolve.sv
source/iss_top.sv
testbench/iss_asserts.sv
testbench/iss_tb.sv
